/* rtl/vpu_pkg.sv */
package vpu_pkg;

    // ==============================
    // datapath geometry
    // ==============================
    localparam int LANES    = 4;
    localparam int LANE_W   = 16;
    localparam int NUM_REGS = 8;
    localparam int VEC_W    = LANES * LANE_W;
    localparam int REG_AW   = $clog2(NUM_REGS);
    localparam int MEM_AW   = 12;
    localparam int PC_W     = 8;
    localparam int INSTR_W  = 32;
    localparam int IMM_W    = 12;

    // ==============================
    // instruction fields
    // ==============================
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;
    localparam int VD_MSB  = 27;
    localparam int VD_LSB  = 25;
    localparam int VS1_MSB = 24;
    localparam int VS1_LSB = 22;
    localparam int VS2_MSB = 21;
    localparam int VS2_LSB = 19;
    localparam int IMM_MSB = 11;
    localparam int IMM_LSB = 0;

    typedef logic [LANE_W-1:0]  lane_t;
    // lane i sits at bits 16i+15 .. 16i
    typedef logic [VEC_W-1:0]   vec_t;
    typedef logic [REG_AW-1:0]  reg_addr_t;
    typedef logic [MEM_AW-1:0]  mem_addr_t;
    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [IMM_W-1:0]   imm_t;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_VADD   = 4'd1,
        OP_VSUB   = 4'd2,
        OP_VAND   = 4'd3,
        OP_VOR    = 4'd4,
        OP_VXOR   = 4'd5,
        OP_VADDI  = 4'd6,
        OP_VLOAD  = 4'd7,
        OP_VSTORE = 4'd8,
        OP_JUMP   = 4'd9
    } opcode_e;

    // source of a register write
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2
    } wb_sel_e;

endpackage

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           advance,
    input  logic           jump,
    input  vpu_pkg::pc_t   jump_target,
    output vpu_pkg::pc_t   pc
);

    vpu_pkg::pc_t pc_next;

    // jump target wins over sequential fetch, no delay slot
    assign pc_next = jump ? jump_target : pc + vpu_pkg::pc_t'(1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  vpu_pkg::instr_t    instr,
    input  vpu_pkg::reg_addr_t ex_vd,
    input  logic               ex_is_load,
    output vpu_pkg::opcode_e   opcode,
    output vpu_pkg::reg_addr_t vd,
    output vpu_pkg::reg_addr_t vs1,
    output vpu_pkg::reg_addr_t vs2,
    output vpu_pkg::imm_t      imm,
    output vpu_pkg::wb_sel_e   wb_sel,
    output logic               mem_write,
    output logic               jump,
    output logic               stall
);

    logic [vpu_pkg::OPC_MSB-vpu_pkg::OPC_LSB:0] opc_raw;
    logic                                       use_vs1;
    logic                                       use_vs2;

    // ==============================
    // field split
    // ==============================
    assign opc_raw = instr[vpu_pkg::OPC_MSB:vpu_pkg::OPC_LSB];
    assign vd      = instr[vpu_pkg::VD_MSB:vpu_pkg::VD_LSB];
    assign vs1     = instr[vpu_pkg::VS1_MSB:vpu_pkg::VS1_LSB];
    assign vs2     = instr[vpu_pkg::VS2_MSB:vpu_pkg::VS2_LSB];
    assign imm     = instr[vpu_pkg::IMM_MSB:vpu_pkg::IMM_LSB];

    // ==============================
    // control
    // ==============================
    always_comb begin
        opcode    = vpu_pkg::OP_NOP;
        wb_sel    = vpu_pkg::WB_NONE;
        mem_write = 1'b0;
        jump      = 1'b0;
        use_vs1   = 1'b0;
        use_vs2   = 1'b0;
        case (opc_raw)
            vpu_pkg::OP_VADD,
            vpu_pkg::OP_VSUB,
            vpu_pkg::OP_VAND,
            vpu_pkg::OP_VOR,
            vpu_pkg::OP_VXOR: begin
                opcode  = vpu_pkg::opcode_e'(opc_raw);
                wb_sel  = vpu_pkg::WB_ALU;
                use_vs1 = 1'b1;
                use_vs2 = 1'b1;
            end
            vpu_pkg::OP_VADDI: begin
                opcode  = vpu_pkg::OP_VADDI;
                wb_sel  = vpu_pkg::WB_ALU;
                use_vs1 = 1'b1;
            end
            vpu_pkg::OP_VLOAD: begin
                opcode = vpu_pkg::OP_VLOAD;
                wb_sel = vpu_pkg::WB_MEM;
            end
            vpu_pkg::OP_VSTORE: begin
                opcode    = vpu_pkg::OP_VSTORE;
                mem_write = 1'b1;
                use_vs2   = 1'b1;
            end
            vpu_pkg::OP_JUMP: begin
                opcode = vpu_pkg::OP_JUMP;
                jump   = 1'b1;
            end
            // unknown codes fall through as nop
            default: ;
        endcase
    end

    // load in EX feeding a source of this instruction
    assign stall = ex_is_load && ((use_vs1 && (vs1 == ex_vd)) ||
                                  (use_vs2 && (vs2 == ex_vd)));

endmodule

/* rtl/vector_regfile.sv */
`timescale 1ns/1ps

module vector_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  vpu_pkg::reg_addr_t waddr,
    input  vpu_pkg::vec_t      wdata,
    input  vpu_pkg::reg_addr_t raddr1,
    input  vpu_pkg::reg_addr_t raddr2,
    output vpu_pkg::vec_t      rdata1,
    output vpu_pkg::vec_t      rdata2
);

    vpu_pkg::vec_t regs [vpu_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < vpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // write port bypass so WB and ID can overlap
    assign rdata1 = (we && (waddr == raddr1)) ? wdata : regs[raddr1];
    assign rdata2 = (we && (waddr == raddr2)) ? wdata : regs[raddr2];

endmodule

/* rtl/vector_alu.sv */
`timescale 1ns/1ps

module vector_alu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             enable,
    input  vpu_pkg::opcode_e opcode,
    input  vpu_pkg::imm_t    imm,
    input  vpu_pkg::vec_t    vec_a,
    input  vpu_pkg::vec_t    vec_b,
    output vpu_pkg::vec_t    vec_out
);

    vpu_pkg::lane_t imm_lane;
    vpu_pkg::vec_t  result;

    // immediate is zero extended into a lane
    assign imm_lane = {{(vpu_pkg::LANE_W-vpu_pkg::IMM_W){1'b0}}, imm};

    always_comb begin
        vpu_pkg::lane_t a_l;
        vpu_pkg::lane_t b_l;
        vpu_pkg::lane_t r_l;
        result = '0;
        for (int i = 0; i < vpu_pkg::LANES; i++) begin
            a_l = vec_a[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W];
            b_l = vec_b[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W];
            case (opcode)
                vpu_pkg::OP_VADD:  r_l = a_l + b_l;
                vpu_pkg::OP_VSUB:  r_l = a_l - b_l;
                vpu_pkg::OP_VAND:  r_l = a_l & b_l;
                vpu_pkg::OP_VOR:   r_l = a_l | b_l;
                vpu_pkg::OP_VXOR:  r_l = a_l ^ b_l;
                vpu_pkg::OP_VADDI: r_l = a_l + imm_lane;
                default:           r_l = '0;
            endcase
            result[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W] = r_l;
        end
    end

    // result register, MEM stage value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vec_out <= '0;
        end else if (enable) begin
            vec_out <= result;
        end
    end

endmodule

/* rtl/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
    input  vpu_pkg::reg_addr_t src,
    input  vpu_pkg::vec_t      rf_data,
    input  vpu_pkg::reg_addr_t mem_vd,
    input  logic               mem_fwd_ok,
    input  vpu_pkg::vec_t      mem_data,
    input  vpu_pkg::reg_addr_t wb_vd,
    input  logic               wb_we,
    input  vpu_pkg::vec_t      wb_data,
    output vpu_pkg::vec_t      operand
);

    logic hit_mem;
    logic hit_wb;

    // only ALU results exist yet in MEM
    assign hit_mem = mem_fwd_ok && (mem_vd == src);
    assign hit_wb  = wb_we && (wb_vd == src);

    // youngest producer first
    always_comb begin
        if (hit_mem) begin
            operand = mem_data;
        end else if (hit_wb) begin
            operand = wb_data;
        end else begin
            operand = rf_data;
        end
    end

endmodule

/* rtl/vpu_core.sv */
`timescale 1ns/1ps

module vpu_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    output vpu_pkg::pc_t       pc,
    input  vpu_pkg::instr_t    instr,
    output vpu_pkg::mem_addr_t mem_addr,
    output logic               mem_read,
    output logic               mem_write,
    output vpu_pkg::vec_t      mem_wdata,
    input  vpu_pkg::vec_t      mem_rdata,
    output logic               data_out_vld,
    output vpu_pkg::vec_t      data_out,
    output vpu_pkg::reg_addr_t reg_wb
);

    // ID stage
    vpu_pkg::opcode_e   id_opcode;
    vpu_pkg::reg_addr_t id_vd;
    vpu_pkg::reg_addr_t id_vs1;
    vpu_pkg::reg_addr_t id_vs2;
    vpu_pkg::imm_t      id_imm;
    vpu_pkg::wb_sel_e   id_wb_sel;
    logic               id_store;
    logic               id_jump;
    vpu_pkg::vec_t      id_rdata1;
    vpu_pkg::vec_t      id_rdata2;
    logic               stall;
    logic               advance;
    vpu_pkg::pc_t       jump_target;
    // EX stage
    vpu_pkg::opcode_e   ex_opcode;
    vpu_pkg::reg_addr_t ex_vd;
    vpu_pkg::reg_addr_t ex_vs1;
    vpu_pkg::reg_addr_t ex_vs2;
    vpu_pkg::imm_t      ex_imm;
    vpu_pkg::wb_sel_e   ex_wb_sel;
    logic               ex_store;
    logic               ex_is_load;
    vpu_pkg::vec_t      ex_rdata1;
    vpu_pkg::vec_t      ex_rdata2;
    vpu_pkg::vec_t      operand_a;
    vpu_pkg::vec_t      operand_b;
    // MEM stage
    vpu_pkg::vec_t      alu_out;
    vpu_pkg::reg_addr_t mem_vd;
    vpu_pkg::wb_sel_e   mem_wb_sel;
    // WB stage
    vpu_pkg::reg_addr_t wb_vd;
    vpu_pkg::wb_sel_e   wb_wb_sel;
    vpu_pkg::vec_t      wb_alu_data;
    vpu_pkg::vec_t      wb_mem_data;
    vpu_pkg::vec_t      wb_data;
    logic               wb_we;

    // ==============================
    // fetch and decode
    // ==============================
    assign advance     = en && !stall;
    assign jump_target = id_imm[vpu_pkg::PC_W-1:0];

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .jump        (id_jump),
        .jump_target (jump_target),
        .pc          (pc)
    );

    assign ex_is_load = (ex_wb_sel == vpu_pkg::WB_MEM);

    instr_decoder u_decoder (
        .instr      (instr),
        .ex_vd      (ex_vd),
        .ex_is_load (ex_is_load),
        .opcode     (id_opcode),
        .vd         (id_vd),
        .vs1        (id_vs1),
        .vs2        (id_vs2),
        .imm        (id_imm),
        .wb_sel     (id_wb_sel),
        .mem_write  (id_store),
        .jump       (id_jump),
        .stall      (stall)
    );

    vector_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (en && wb_we),
        .waddr  (wb_vd),
        .wdata  (wb_data),
        .raddr1 (id_vs1),
        .raddr2 (id_vs2),
        .rdata1 (id_rdata1),
        .rdata2 (id_rdata2)
    );

    // ==============================
    // execute
    // ==============================
    operand_forward u_fwd_a (
        .src        (ex_vs1),
        .rf_data    (ex_rdata1),
        .mem_vd     (mem_vd),
        .mem_fwd_ok (mem_wb_sel == vpu_pkg::WB_ALU),
        .mem_data   (alu_out),
        .wb_vd      (wb_vd),
        .wb_we      (wb_we),
        .wb_data    (wb_data),
        .operand    (operand_a)
    );

    operand_forward u_fwd_b (
        .src        (ex_vs2),
        .rf_data    (ex_rdata2),
        .mem_vd     (mem_vd),
        .mem_fwd_ok (mem_wb_sel == vpu_pkg::WB_ALU),
        .mem_data   (alu_out),
        .wb_vd      (wb_vd),
        .wb_we      (wb_we),
        .wb_data    (wb_data),
        .operand    (operand_b)
    );

    vector_alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (en),
        .opcode  (ex_opcode),
        .imm     (ex_imm),
        .vec_a   (operand_a),
        .vec_b   (operand_b),
        .vec_out (alu_out)
    );

    // memory request goes out from EX, data back during MEM
    assign mem_addr  = ex_imm;
    assign mem_wdata = operand_b;
    assign mem_read  = en && ex_is_load;
    assign mem_write = en && ex_store;

    // ==============================
    // write back
    // ==============================
    always_comb begin
        case (wb_wb_sel)
            vpu_pkg::WB_ALU: wb_data = wb_alu_data;
            vpu_pkg::WB_MEM: wb_data = wb_mem_data;
            default:         wb_data = '0;
        endcase
    end

    assign wb_we        = (wb_wb_sel != vpu_pkg::WB_NONE);
    assign data_out_vld = en && wb_we;
    assign data_out     = wb_data;
    assign reg_wb       = wb_vd;

    // ==============================
    // pipeline registers
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_opcode  <= vpu_pkg::OP_NOP;
            ex_wb_sel  <= vpu_pkg::WB_NONE;
            ex_store   <= 1'b0;
            mem_wb_sel <= vpu_pkg::WB_NONE;
            wb_wb_sel  <= vpu_pkg::WB_NONE;
        end else if (en) begin
            if (stall) begin
                // bubble behind the load
                ex_opcode <= vpu_pkg::OP_NOP;
                ex_wb_sel <= vpu_pkg::WB_NONE;
                ex_store  <= 1'b0;
            end else begin
                ex_opcode <= id_opcode;
                ex_wb_sel <= id_wb_sel;
                ex_store  <= id_store;
            end
            mem_wb_sel <= ex_wb_sel;
            wb_wb_sel  <= mem_wb_sel;
        end
    end

    // payload, qualified by the control above
    always_ff @(posedge clk) begin
        if (en) begin
            ex_vd       <= id_vd;
            ex_vs1      <= id_vs1;
            ex_vs2      <= id_vs2;
            ex_imm      <= id_imm;
            ex_rdata1   <= id_rdata1;
            ex_rdata2   <= id_rdata2;
            mem_vd      <= ex_vd;
            wb_vd       <= mem_vd;
            wb_alu_data <= alu_out;
            wb_mem_data <= mem_rdata;
        end
    end

endmodule

/* verification/vpu_core_tb.sv */
`timescale 1ns/1ps

module vpu_core_tb;

    // summed program words of all tests
    localparam int PROG_WORDS = 49;
    // four cycles per word plus slack for reset and drain
    localparam int MAX_CYCLES = 4 * PROG_WORDS + 100;

    logic               clk;
    logic               rst_n;
    logic               en;
    vpu_pkg::pc_t       pc;
    vpu_pkg::instr_t    instr;
    vpu_pkg::mem_addr_t mem_addr;
    logic               mem_read;
    logic               mem_write;
    vpu_pkg::vec_t      mem_wdata;
    vpu_pkg::vec_t      mem_rdata;
    logic               data_out_vld;
    vpu_pkg::vec_t      data_out;
    vpu_pkg::reg_addr_t reg_wb;

    vpu_pkg::instr_t    rom [256];
    vpu_pkg::vec_t      dmem [4096];
    vpu_pkg::vec_t      ref_mem [4096];
    vpu_pkg::reg_addr_t exp_reg [$];
    vpu_pkg::vec_t      exp_val [$];
    vpu_pkg::mem_addr_t exp_saddr [$];
    vpu_pkg::vec_t      exp_sdata [$];
    integer             seed;
    int                 cycles;

    vpu_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .pc           (pc),
        .instr        (instr),
        .mem_addr     (mem_addr),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .data_out_vld (data_out_vld),
        .data_out     (data_out),
        .reg_wb       (reg_wb)
    );

    // instruction ROM answers in the same cycle
    assign instr = rom[pc];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // data memory with one cycle read latency
    // ==============================
    always @(posedge clk) begin
        logic               rd;
        logic               wr;
        vpu_pkg::mem_addr_t a;
        vpu_pkg::vec_t      wd;
        rd = mem_read;
        wr = mem_write;
        a  = mem_addr;
        wd = mem_wdata;
        #1;
        if (rd) begin
            mem_rdata = dmem[a];
        end
        if (wr) begin
            dmem[a] = wd;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles", MAX_CYCLES);
            stop_on_error("simulation did not finish in time");
        end
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vec(input string name, input vpu_pkg::vec_t exp,
                             input vpu_pkg::vec_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_on_error("vector value differs");
        end
    endtask

    task automatic check_reg(input string name, input vpu_pkg::reg_addr_t exp,
                             input vpu_pkg::reg_addr_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_on_error("register number differs");
        end
    endtask

    task automatic check_addr(input string name, input vpu_pkg::mem_addr_t exp,
                              input vpu_pkg::mem_addr_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            stop_on_error("memory address differs");
        end
    endtask

    task automatic check_pc(input string name, input vpu_pkg::pc_t exp,
                            input vpu_pkg::pc_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            stop_on_error("program counter differs");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            stop_on_error("strobe level differs");
        end
    endtask

    // write backs and stores checked in program order
    always @(negedge clk) begin
        if (rst_n) begin
            if (!en && (data_out_vld || mem_read || mem_write)) begin
                stop_on_error("a strobe was active while en was low");
            end
            if (data_out_vld) begin
                if (exp_reg.size() == 0) begin
                    stop_on_error("write back seen that the program never makes");
                end
                check_reg("reg_wb", exp_reg.pop_front(), reg_wb);
                check_vec("data_out", exp_val.pop_front(), data_out);
            end
            if (mem_write) begin
                if (exp_saddr.size() == 0) begin
                    stop_on_error("store seen that the program never makes");
                end
                check_addr("mem_addr", exp_saddr.pop_front(), mem_addr);
                check_vec("mem_wdata", exp_sdata.pop_front(), mem_wdata);
            end
        end
    end

    // ==============================
    // reference model
    // ==============================
    function automatic vpu_pkg::instr_t enc(input logic [3:0] op, input vpu_pkg::reg_addr_t vd,
                                            input vpu_pkg::reg_addr_t vs1,
                                            input vpu_pkg::reg_addr_t vs2,
                                            input vpu_pkg::imm_t imm);
        return {op, vd, vs1, vs2, 7'd0, imm};
    endfunction

    function automatic vpu_pkg::vec_t lane_op(input logic [3:0] op, input vpu_pkg::vec_t a,
                                              input vpu_pkg::vec_t b, input vpu_pkg::imm_t imm);
        vpu_pkg::vec_t  r;
        vpu_pkg::lane_t x;
        vpu_pkg::lane_t y;
        r = '0;
        for (int i = 0; i < vpu_pkg::LANES; i++) begin
            x = a[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W];
            y = (op == 4'd6) ? {4'd0, imm} : b[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W];
            case (op)
                4'd2:    r[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W] = x - y;
                4'd3:    r[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W] = x & y;
                4'd4:    r[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W] = x | y;
                4'd5:    r[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W] = x ^ y;
                default: r[i*vpu_pkg::LANE_W +: vpu_pkg::LANE_W] = x + y;
            endcase
        end
        return r;
    endfunction

    // a jump to itself ends the sequential run
    task automatic build_expected();
        vpu_pkg::vec_t   regs [8];
        vpu_pkg::pc_t    p;
        vpu_pkg::instr_t w;
        logic [3:0]      op;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        ref_mem = dmem;
        p = '0;
        for (int step = 0; step < 200; step++) begin
            w  = rom[p];
            op = w[31:28];
            if (op == 4'd9) begin
                if (w[7:0] == p) begin
                    break;
                end
                p = w[7:0];
            end else begin
                if (op >= 4'd1 && op <= 4'd6) begin
                    regs[w[27:25]] = lane_op(op, regs[w[24:22]], regs[w[21:19]], w[11:0]);
                    exp_reg.push_back(w[27:25]);
                    exp_val.push_back(regs[w[27:25]]);
                end else if (op == 4'd7) begin
                    regs[w[27:25]] = ref_mem[w[11:0]];
                    exp_reg.push_back(w[27:25]);
                    exp_val.push_back(regs[w[27:25]]);
                end else if (op == 4'd8) begin
                    ref_mem[w[11:0]] = regs[w[21:19]];
                    exp_saddr.push_back(w[11:0]);
                    exp_sdata.push_back(regs[w[21:19]]);
                end
                p = p + 8'd1;
            end
        end
    endtask

    // ==============================
    // run control
    // ==============================
    task automatic hold_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        en    = 1'b1;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
        end
        for (int i = 0; i < 4096; i++) begin
            dmem[i] = {$random(seed), $random(seed)};
        end
    endtask

    task automatic wait_until_drained();
        while (exp_reg.size() > 0 || exp_saddr.size() > 0) begin
            @(posedge clk);
        end
        // a few more cycles to catch stray write backs
        repeat (5) @(posedge clk);
    endtask

    task automatic release_and_run(input int pause_at, input int pause_len);
        build_expected();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (pause_len > 0) begin
            repeat (pause_at) @(posedge clk);
            #1;
            en = 1'b0;
            repeat (pause_len) @(posedge clk);
            #1;
            en = 1'b1;
        end
        wait_until_drained();
    endtask

    // reset lands with the first load in WB and the third word in EX
    task automatic reset_mid_run(input vpu_pkg::instr_t third);
        hold_reset();
        rom[0] = enc(4'd7, 3'd1, 3'd0, 3'd0, 12'd8);
        rom[1] = enc(4'd7, 3'd2, 3'd0, 3'd0, 12'd9);
        rom[2] = third;
        rom[3] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd3);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_pc("pc", 8'd0, pc);
        check_bit("data_out_vld", 1'b0, data_out_vld);
        check_bit("mem_read", 1'b0, mem_read);
        check_bit("mem_write", 1'b0, mem_write);
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_reset();
        reset_mid_run(enc(4'd7, 3'd3, 3'd0, 3'd0, 12'd10));
        reset_mid_run(enc(4'd8, 3'd0, 3'd0, 3'd3, 12'd10));
    endtask

    task automatic test_alu_forwarding();
        hold_reset();
        rom[0] = enc(4'd7, 3'd1, 3'd0, 3'd0, 12'd16);
        rom[1] = enc(4'd7, 3'd2, 3'd0, 3'd0, 12'd17);
        rom[2] = enc(4'd1, 3'd3, 3'd1, 3'd2, 12'd0);
        rom[3] = enc(4'd2, 3'd4, 3'd3, 3'd1, 12'd0);
        rom[4] = enc(4'd3, 3'd5, 3'd4, 3'd3, 12'd0);
        rom[5] = enc(4'd4, 3'd6, 3'd5, 3'd2, 12'd0);
        rom[6] = enc(4'd5, 3'd7, 3'd6, 3'd5, 12'd0);
        rom[7] = enc(4'd6, 3'd1, 3'd7, 3'd0, 12'h5a3);
        rom[8] = enc(4'd1, 3'd2, 3'd1, 3'd1, 12'd0);
        rom[9] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd9);
        release_and_run(0, 0);
    endtask

    task automatic test_store_load();
        hold_reset();
        rom[0] = enc(4'd7, 3'd1, 3'd0, 3'd0, 12'd40);
        rom[1] = enc(4'd6, 3'd2, 3'd1, 3'd0, 12'd7);
        rom[2] = enc(4'd8, 3'd0, 3'd0, 3'd2, 12'd100);
        rom[3] = enc(4'd7, 3'd3, 3'd0, 3'd0, 12'd100);
        rom[4] = enc(4'd5, 3'd4, 3'd3, 3'd1, 12'd0);
        rom[5] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd5);
        release_and_run(0, 0);
    endtask

    task automatic test_load_use();
        hold_reset();
        rom[0] = enc(4'd7, 3'd1, 3'd0, 3'd0, 12'd3);
        rom[1] = enc(4'd1, 3'd2, 3'd1, 3'd1, 12'd0);
        rom[2] = enc(4'd7, 3'd3, 3'd0, 3'd0, 12'd4);
        rom[3] = enc(4'd2, 3'd4, 3'd3, 3'd2, 12'd0);
        rom[4] = enc(4'd7, 3'd5, 3'd0, 3'd0, 12'd5);
        rom[5] = enc(4'd8, 3'd0, 3'd0, 3'd5, 12'd6);
        rom[6] = enc(4'd7, 3'd6, 3'd0, 3'd0, 12'd6);
        rom[7] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd7);
        release_and_run(0, 0);
    endtask

    task automatic test_jump();
        hold_reset();
        rom[0] = enc(4'd7, 3'd1, 3'd0, 3'd0, 12'd1);
        rom[1] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd4);
        rom[2] = enc(4'd6, 3'd2, 3'd1, 3'd0, 12'd1);
        rom[3] = enc(4'd6, 3'd3, 3'd1, 3'd0, 12'd2);
        rom[4] = enc(4'd6, 3'd4, 3'd1, 3'd0, 12'd3);
        rom[5] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd8);
        rom[6] = enc(4'd1, 3'd5, 3'd1, 3'd1, 12'd0);
        rom[7] = enc(4'd1, 3'd6, 3'd1, 3'd1, 12'd0);
        rom[8] = enc(4'd5, 3'd7, 3'd4, 3'd1, 12'd0);
        rom[9] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd9);
        build_expected();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        while (pc != 8'd1) begin
            @(negedge clk);
        end
        // jump sits in ID so the target follows directly
        @(negedge clk);
        check_pc("pc", 8'd4, pc);
        wait_until_drained();
    endtask

    task automatic test_enable_pause();
        hold_reset();
        rom[0] = enc(4'd7, 3'd1, 3'd0, 3'd0, 12'd20);
        rom[1] = enc(4'd1, 3'd2, 3'd1, 3'd1, 12'd0);
        rom[2] = enc(4'd8, 3'd0, 3'd0, 3'd2, 12'd21);
        rom[3] = enc(4'd7, 3'd3, 3'd0, 3'd0, 12'd21);
        rom[4] = enc(4'd2, 3'd4, 3'd3, 3'd1, 12'd0);
        rom[5] = enc(4'd6, 3'd5, 3'd4, 3'd0, 12'd9);
        rom[6] = enc(4'd9, 3'd0, 3'd0, 3'd0, 12'd6);
        release_and_run(4, 6);
    endtask

    initial begin
        seed      = 32'heed4;
        cycles    = 0;
        rst_n     = 1'b0;
        en        = 1'b0;
        mem_rdata = '0;
        test_reset();
        test_alu_forwarding();
        test_store_load();
        test_load_use();
        test_jump();
        test_enable_pause();
        if (exp_reg.size() == 0 && exp_saddr.size() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/vpu_pkg.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
rtl/vector_regfile.sv
rtl/vector_alu.sv
rtl/operand_forward.sv
rtl/vpu_core.sv
verification/vpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vpu_core testbench with Verilator

verilator --binary --timing -f verilog.f --top-module vpu_core_tb -o vpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/vpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation PASSED"
exit 0
